// ==== project.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/decode_types_pkg.sv
verilog/decode_lane.sv
verilog/lane_dispatch.sv
verilog/lane_collect.sv
verilog/decode_cluster.sv
tb/decode_cluster_chk.sv
tb/decode_cluster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode cluster testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f project.f --top-module decode_cluster_tb \
  -o decode_cluster_sim > build.log 2>&1 \
  && ./obj_dir/decode_cluster_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Testbench failed" sim.log \
  && { tail -n 20 sim.log; exit 1; } \
  || { tail -n 2 sim.log; exit 0; }

// ==== tb/decode_cluster_chk.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_cluster_chk
  import rv_isa_pkg::*;
  import decode_types_pkg::*;
(
  input logic clk_i,
  input logic reset_i,
  input logic in_valid_i,
  input logic in_ready_i,
  input logic out_valid_i,
  input uop_t out_uop_i,
  input logic out_ready_i
);

  // packets accepted but not yet delivered
  int in_flight_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight_q <= 0;
    end else begin
      case ({in_valid_i && in_ready_i, out_valid_i && out_ready_i})
        2'b10:   in_flight_q <= in_flight_q + 1;
        2'b01:   in_flight_q <= in_flight_q - 1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  // ==================================================
  // output stream
  // ==================================================
  hold_payload: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_uop_i))
    else $error("out_uop_o changed or valid dropped while stalled");

  idle_in_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
    else $error("out_valid_o high during reset");

  illegal_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i && out_uop_i.illegal |->
      !(out_uop_i.reg_we || out_uop_i.mem_rd || out_uop_i.mem_wr))
    else $error("illegal uop with an enable set");

  // never more packets held than lanes
  lane_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    in_flight_q <= `NUM_LANES)
    else $error("more packets in flight than decode lanes");

endmodule

// ==== tb/decode_cluster_tb.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_cluster_tb
  import rv_isa_pkg::*;
  import decode_types_pkg::*;
;

  logic      clk_i;
  logic      reset_i;
  logic      in_valid_i;
  inst_pkt_t in_pkt_i;
  logic      in_ready_o;
  logic      out_valid_o;
  uop_t      out_uop_o;
  logic      out_ready_i;

  inst_pkt_t   pkt_q[$];
  uop_t        exp_q[$];
  int          num_entries    = 0;
  int          checked        = 0;
  int          value_errors   = 0;
  int          flow_errors    = 0;
  int          timeout_errors = 0;
  logic        trace_loaded   = 1'b0;
  int unsigned gap;

  decode_cluster dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_pkt_i    (in_pkt_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_uop_o   (out_uop_o),
    .out_ready_i (out_ready_i)
  );

  bind decode_cluster decode_cluster_chk u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_uop_i   (out_uop_o),
    .out_ready_i (out_ready_i)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // ==================================================
  // compare tasks by result type
  // ==================================================
  task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                            input logic [`XLEN-1:0] act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_width(input string name, input mem_width_e exp, input mem_width_e act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_uop(input int idx, input uop_t exp, input uop_t act);
    string p;
    p = $sformatf("out_uop_o[%0d]", idx);
    check_alu_op({p, ".alu_op"}, exp.alu_op, act.alu_op);
    check_word({p, ".op1"}, exp.op1, act.op1);
    check_word({p, ".op2"}, exp.op2, act.op2);
    check_word({p, ".rd"}, `XLEN'(exp.rd), `XLEN'(act.rd));
    check_bit({p, ".reg_we"}, exp.reg_we, act.reg_we);
    check_bit({p, ".mem_rd"}, exp.mem_rd, act.mem_rd);
    check_bit({p, ".mem_wr"}, exp.mem_wr, act.mem_wr);
    check_width({p, ".mem_width"}, exp.mem_width, act.mem_width);
    check_word({p, ".store_data"}, exp.store_data, act.store_data);
    check_bit({p, ".br_taken"}, exp.br_taken, act.br_taken);
    check_word({p, ".br_target"}, exp.br_target, act.br_target);
    check_bit({p, ".illegal"}, exp.illegal, act.illegal);
  endtask

  // ==================================================
  // trace file with one packet and its uop per line
  // ==================================================
  task automatic load_trace();
    int               fd;
    int               got;
    string            line;
    inst_pkt_t        p;
    uop_t             e;
    logic [`XLEN-1:0] f_pc, f_inst, f_rs1, f_rs2, f_alu, f_op1, f_op2, f_rd;
    logic [`XLEN-1:0] f_we, f_mrd, f_mwr, f_width, f_sd, f_bt, f_btgt, f_ill;
    fd = $fopen("tb/decode_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/decode_trace.txt");
      flow_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() < 4 || line.getc(0) == "#") continue;
      got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_pc, f_inst, f_rs1, f_rs2, f_alu, f_op1, f_op2, f_rd,
                    f_we, f_mrd, f_mwr, f_width, f_sd, f_bt, f_btgt, f_ill);
      if (got != 16) begin
        $display("trace line could not be parsed: %s", line);
        flow_errors++;
        continue;
      end
      p.pc         = f_pc;
      p.inst       = f_inst[31:0];
      p.rs1_val    = f_rs1;
      p.rs2_val    = f_rs2;
      e.alu_op     = alu_op_e'(f_alu[4:0]);
      e.op1        = f_op1;
      e.op2        = f_op2;
      e.rd         = f_rd[4:0];
      e.reg_we     = f_we[0];
      e.mem_rd     = f_mrd[0];
      e.mem_wr     = f_mwr[0];
      e.mem_width  = mem_width_e'(f_width[2:0]);
      e.store_data = f_sd;
      e.br_taken   = f_bt[0];
      e.br_target  = f_btgt;
      e.illegal    = f_ill[0];
      pkt_q.push_back(p);
      exp_q.push_back(e);
    end
    $fclose(fd);
    num_entries = pkt_q.size();
  endtask

  // hold valid and payload until the lane takes it
  task automatic send_packet(input inst_pkt_t pkt);
    in_valid_i = 1'b1;
    in_pkt_i   = pkt;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic report_and_finish();
    $display("checked %0d of %0d uops: %0d value errors, %0d flow errors, %0d timeouts",
             checked, num_entries, value_errors, flow_errors, timeout_errors);
    if (value_errors + flow_errors + timeout_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    void'($urandom(32'h76e7_ee49));
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    in_pkt_i    = '0;
    out_ready_i = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    if (num_entries == 0) begin
      $display("no usable entries found in the trace file");
      flow_errors++;
    end else begin
      repeat (5) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      foreach (pkt_q[i]) begin
        gap = $urandom % 3;
        repeat (gap) begin
          @(posedge clk_i);
          #1;
        end
        send_packet(pkt_q[i]);
      end
      wait (checked == num_entries);
      // a few idle cycles catch any extra output
      repeat (4) @(negedge clk_i);
    end
    report_and_finish();
  end

  // random back-pressure with ready about 3 cycles in 4
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      out_ready_i = ($urandom % 4) != 32'd0;
    end
  end

  // outputs settle by the falling edge
  always @(negedge clk_i) begin : monitor
    uop_t exp_uop;
    if (!reset_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("output transfer at %0t with no uop left to expect", $time);
        flow_errors++;
      end else begin
        exp_uop = exp_q.pop_front();
        compare_uop(checked, exp_uop, out_uop_o);
        checked++;
      end
    end
  end

  initial begin : watchdog
    wait (trace_loaded);
    repeat (num_entries * 20 + 200) @(posedge clk_i);
    $display("watchdog expired, only %0d of %0d uops came out", checked, num_entries);
    timeout_errors++;
    report_and_finish();
  end

endmodule

// ==== tb/decode_trace.txt ====
# pc inst rs1_val rs2_val alu_op op1 op2 rd reg_we mem_rd mem_wr mem_width store_data
# br_taken br_target illegal, all hex, alu_op and mem_width as enum codes
1000 003100b3 123 45 01 123 45 01 1 0 0 0 0 0 0 0
1004 403100b3 123 45 03 123 45 01 1 0 0 0 0 0 0 0
1008 40315233 123 45 0e 123 45 04 1 0 0 0 0 0 0 0
100c 003132b3 123 45 06 123 45 05 1 0 0 0 0 0 0 0
1010 02310333 123 45 10 123 45 06 1 0 0 0 0 0 0 0
1014 023173b3 123 45 17 123 45 07 1 0 0 0 0 0 0 0
1018 0031043b 123 45 02 123 45 08 1 0 0 0 0 0 0 0
101c 023154bb 123 45 15 123 45 09 1 0 0 0 0 0 0 0
1020 ffb10093 1000 0 01 1000 fffffffffffffffb 01 1 0 0 0 0 0 0 0
1024 7ff14193 1000 0 09 1000 7ff 03 1 0 0 0 0 0 0 0
1028 02111213 1000 0 0a 1000 21 04 1 0 0 0 0 0 0 0
102c 43f15293 1000 0 0e 1000 43f 05 1 0 0 0 0 0 0 0
1030 0641039b 1000 0 02 1000 64 07 1 0 0 0 0 0 0 0
1034 4031541b 1000 0 0f 1000 403 08 1 0 0 0 0 0 0 0
1038 ff812483 80000000 0 01 80000000 fffffffffffffff8 09 1 1 0 5 0 0 0 0
103c 01014503 80000000 0 01 80000000 10 0a 1 1 0 2 0 0 0 0
1040 00013583 80000000 0 01 80000000 0 0b 1 1 0 7 0 0 0 0
1044 00313c23 80000000 deadbeefcafef00d 01 80000000 18 00 0 0 1 7 deadbeefcafef00d 0 0 0
1048 fe310fa3 80000000 deadbeefcafef00d 01 80000000 ffffffffffffffff 00 0 0 1 1 deadbeefcafef00d 0 0 0
104c 00310863 77 77 00 0 0 00 0 0 0 0 0 1 105c 0
1050 fe314ce3 ffffffffffffffff 1 00 0 0 00 0 0 0 0 0 1 1048 0
1054 fe316ce3 ffffffffffffffff 1 00 0 0 00 0 0 0 0 0 0 104c 0
1058 02317063 5 5 00 0 0 00 0 0 0 0 0 1 1078 0
105c 001000ef 0 0 01 105c 4 01 1 0 0 0 0 1 185c 0
1060 ffdff06f 0 0 01 1060 4 00 1 0 0 0 0 1 105c 0
1064 005100e7 2000 0 01 1064 4 01 1 0 0 0 0 1 2004 0
1068 800002b7 0 0 01 0 ffffffff80000000 05 1 0 0 0 0 0 0 0
106c 12345317 0 0 01 106c 12345000 06 1 0 0 0 0 0 0 0
1070 00000073 123 45 00 0 0 00 0 0 0 0 0 0 0 1
1074 203100b3 123 45 00 0 0 00 0 0 0 0 0 0 0 1
1078 0201121b 1000 0 00 0 0 00 0 0 0 0 0 0 0 1

// ==== verilog/decode_cluster.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_cluster
  import decode_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      in_valid_i,
  input  inst_pkt_t in_pkt_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  output uop_t      out_uop_o,
  input  logic      out_ready_i
);

  // dispatcher side
  logic lane_in_valid  [`NUM_LANES];
  logic lane_in_ready  [`NUM_LANES];
  // collector side
  logic lane_out_valid [`NUM_LANES];
  logic lane_out_ready [`NUM_LANES];
  uop_t lane_uop       [`NUM_LANES];

  lane_dispatch u_dispatch (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .lane_valid_o (lane_in_valid),
    .lane_ready_i (lane_in_ready)
  );

  // ==================================================
  // decode lanes, packet bus shared by all
  // ==================================================
  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    decode_lane u_lane (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (lane_in_valid[g]),
      .in_pkt_i    (in_pkt_i),
      .in_ready_o  (lane_in_ready[g]),
      .out_valid_o (lane_out_valid[g]),
      .out_uop_o   (lane_uop[g]),
      .out_ready_i (lane_out_ready[g])
    );
  end

  lane_collect u_collect (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lane_valid_i (lane_out_valid),
    .lane_uop_i   (lane_uop),
    .lane_ready_o (lane_out_ready),
    .out_valid_o  (out_valid_o),
    .out_uop_o    (out_uop_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

// ==== verilog/decode_lane.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_lane
  import rv_isa_pkg::*;
  import decode_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      in_valid_i,
  input  inst_pkt_t in_pkt_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  output uop_t      out_uop_o,
  input  logic      out_ready_i
);

  logic [31:0]      inst;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [4:0]       rd;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  logic br_eq;
  logic br_lt;
  logic br_ltu;
  logic br_cond;

  uop_t dec;
  uop_t uop_q;
  logic full_q;

  assign inst    = in_pkt_i.inst;
  assign pc      = in_pkt_i.pc;
  assign rs1_val = in_pkt_i.rs1_val;
  assign rs2_val = in_pkt_i.rs2_val;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ==================================================
  // immediates, all sign-extended
  // ==================================================
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ==================================================
  // branch resolution
  // ==================================================
  assign br_eq  = (rs1_val == rs2_val);
  assign br_lt  = ($signed(rs1_val) < $signed(rs2_val));
  assign br_ltu = (rs1_val < rs2_val);

  always_comb begin
    case (funct3)
      BR_EQ:   br_cond = br_eq;
      BR_NE:   br_cond = !br_eq;
      BR_LT:   br_cond = br_lt;
      BR_GE:   br_cond = !br_lt;
      BR_LTU:  br_cond = br_ltu;
      BR_GEU:  br_cond = !br_ltu;
      default: br_cond = 1'b0;
    endcase
  end

  // the eight funct3 ops shared by OP and OP_IMM
  function automatic alu_op_e base_alu(input logic [2:0] f3);
    alu_op_e op;
    case (f3)
      3'b000:  op = ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ==================================================
  // main decode
  // ==================================================
  always_comb begin
    dec = '0;
    case (opcode)
      OPC_OP: begin
        dec.op1    = rs1_val;
        dec.op2    = rs2_val;
        dec.reg_we = 1'b1;
        case (funct7)
          F7_BASE: dec.alu_op = base_alu(funct3);
          F7_ALT: begin
            if (funct3 == 3'b000) dec.alu_op = ALU_SUB;
            else if (funct3 == 3'b101) dec.alu_op = ALU_SRA;
            else dec.illegal = 1'b1;
          end
          F7_MULDIV: begin
            case (funct3)
              3'b000:  dec.alu_op = ALU_MUL;
              3'b100:  dec.alu_op = ALU_DIV;
              3'b101:  dec.alu_op = ALU_DIVU;
              3'b110:  dec.alu_op = ALU_REM;
              3'b111:  dec.alu_op = ALU_REMU;
              // mulh variants not supported
              default: dec.illegal = 1'b1;
            endcase
          end
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_OP_32: begin
        dec.op1    = rs1_val;
        dec.op2    = rs2_val;
        dec.reg_we = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}:   dec.alu_op = ALU_ADDW;
          {F7_BASE, 3'b001}:   dec.alu_op = ALU_SLLW;
          {F7_BASE, 3'b101}:   dec.alu_op = ALU_SRLW;
          {F7_ALT, 3'b000}:    dec.alu_op = ALU_SUBW;
          {F7_ALT, 3'b101}:    dec.alu_op = ALU_SRAW;
          {F7_MULDIV, 3'b000}: dec.alu_op = ALU_MULW;
          {F7_MULDIV, 3'b100}: dec.alu_op = ALU_DIVW;
          {F7_MULDIV, 3'b101}: dec.alu_op = ALU_DIVUW;
          {F7_MULDIV, 3'b110}: dec.alu_op = ALU_REMW;
          {F7_MULDIV, 3'b111}: dec.alu_op = ALU_REMUW;
          default:             dec.illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        dec.op1    = rs1_val;
        dec.op2    = imm_i;
        dec.reg_we = 1'b1;
        // rv64 shamt is 6 bits, so only inst[31:26] selects the shift
        if (funct3 == 3'b001 && inst[31:26] != 6'b000000) dec.illegal = 1'b1;
        else if (funct3 == 3'b101 && inst[31:26] == 6'b010000) dec.alu_op = ALU_SRA;
        else if (funct3 == 3'b101 && inst[31:26] != 6'b000000) dec.illegal = 1'b1;
        else dec.alu_op = base_alu(funct3);
      end
      OPC_OP_IMM_32: begin
        dec.op1    = rs1_val;
        dec.op2    = imm_i;
        dec.reg_we = 1'b1;
        // imm[5] set leaves funct7 outside both groups
        case ({funct7, funct3}) inside
          {F7_BASE, 3'b001}: dec.alu_op = ALU_SLLW;
          {F7_BASE, 3'b101}: dec.alu_op = ALU_SRLW;
          {F7_ALT, 3'b101}:  dec.alu_op = ALU_SRAW;
          {7'b???????, 3'b000}: dec.alu_op = ALU_ADDW;
          default:           dec.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dec.alu_op = ALU_ADD;
        dec.op1    = rs1_val;
        dec.op2    = imm_i;
        dec.reg_we = 1'b1;
        dec.mem_rd = 1'b1;
        case (funct3)
          3'b000:  dec.mem_width = MEM_B;
          3'b001:  dec.mem_width = MEM_H;
          3'b010:  dec.mem_width = MEM_W;
          3'b011:  dec.mem_width = MEM_D;
          3'b100:  dec.mem_width = MEM_BU;
          3'b101:  dec.mem_width = MEM_HU;
          3'b110:  dec.mem_width = MEM_WU;
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        dec.alu_op     = ALU_ADD;
        dec.op1        = rs1_val;
        dec.op2        = imm_s;
        dec.mem_wr     = 1'b1;
        dec.store_data = rs2_val;
        case (funct3)
          3'b000:  dec.mem_width = MEM_B;
          3'b001:  dec.mem_width = MEM_H;
          3'b010:  dec.mem_width = MEM_W;
          3'b011:  dec.mem_width = MEM_D;
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_BRANCH: begin
        dec.br_taken  = br_cond;
        dec.br_target = pc + imm_b;
        if (funct3 == 3'b010 || funct3 == 3'b011) dec.illegal = 1'b1;
      end
      OPC_JAL: begin
        dec.alu_op    = ALU_ADD;
        dec.op1       = pc;
        dec.op2       = `XLEN'd4;
        dec.reg_we    = 1'b1;
        dec.br_taken  = 1'b1;
        dec.br_target = pc + imm_j;
      end
      OPC_JALR: begin
        dec.alu_op    = ALU_ADD;
        dec.op1       = pc;
        dec.op2       = `XLEN'd4;
        dec.reg_we    = 1'b1;
        dec.br_taken  = 1'b1;
        dec.br_target = (rs1_val + imm_i) & ~`XLEN'd1;
        if (funct3 != 3'b000) dec.illegal = 1'b1;
      end
      OPC_LUI: begin
        dec.alu_op = ALU_ADD;
        dec.op2    = imm_u;
        dec.reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        dec.alu_op = ALU_ADD;
        dec.op1    = pc;
        dec.op2    = imm_u;
        dec.reg_we = 1'b1;
      end
      // SYSTEM included, no csr support
      default: dec.illegal = 1'b1;
    endcase

    // rd only reported for writing uops
    if (dec.reg_we) dec.rd = rd;

    // illegal squashes every field
    if (dec.illegal) begin
      dec = '0;
      dec.illegal = 1'b1;
    end
  end

  // ==================================================
  // one-entry output buffer
  // ==================================================
  assign in_ready_o  = !full_q || out_ready_i;
  assign out_valid_o = full_q;
  assign out_uop_o   = uop_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      uop_q <= dec;
    end
  end

endmodule

// ==== verilog/decode_types_pkg.sv ====
`include "rv_decode_config.svh"

package decode_types_pkg;

  import rv_isa_pkg::*;

  // ==================================================
  // instruction packet, 224 bits
  // ==================================================
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
  } inst_pkt_t;

  // ==================================================
  // decoded micro-op
  // ==================================================
  typedef struct packed {
    alu_op_e          alu_op;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [4:0]       rd;
    logic             reg_we;
    logic             mem_rd;
    logic             mem_wr;
    mem_width_e       mem_width;
    logic [`XLEN-1:0] store_data;
    // resolved in decode, jal/jalr always taken
    logic             br_taken;
    logic [`XLEN-1:0] br_target;
    logic             illegal;
  } uop_t;

endpackage

// ==== verilog/lane_collect.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module lane_collect
  import decode_types_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic lane_valid_i [`NUM_LANES],
  input  uop_t lane_uop_i   [`NUM_LANES],
  output logic lane_ready_o [`NUM_LANES],
  output logic out_valid_o,
  output uop_t out_uop_o,
  input  logic out_ready_i
);

  localparam int IDX_W = `LANE_IDX_W;

  logic [IDX_W-1:0] rd_ptr_q;
  logic             out_fire;

  // output mux, follows program order
  assign out_valid_o = lane_valid_i[rd_ptr_q];
  assign out_uop_o   = lane_uop_i[rd_ptr_q];
  assign out_fire    = out_valid_o && out_ready_i;

  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_ready
    assign lane_ready_o[g] = out_ready_i && (rd_ptr_q == IDX_W'(g));
  end

  // ==================================================
  // read pointer, same order as dispatch
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
    end else if (out_fire) begin
      if (rd_ptr_q == IDX_W'(`NUM_LANES - 1)) begin
        rd_ptr_q <= '0;
      end else begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/lane_dispatch.sv ====
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module lane_dispatch (
  input  logic clk_i,
  input  logic reset_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  output logic lane_valid_o [`NUM_LANES],
  input  logic lane_ready_i [`NUM_LANES]
);

  localparam int IDX_W = `LANE_IDX_W;

  logic [IDX_W-1:0] wr_ptr_q;
  logic             in_fire;

  // only the lane under the pointer sees valid
  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_valid
    assign lane_valid_o[g] = in_valid_i && (wr_ptr_q == IDX_W'(g));
  end

  assign in_ready_o = lane_ready_i[wr_ptr_q];
  assign in_fire    = in_valid_i && in_ready_o;

  // ==================================================
  // write pointer, wraps at NUM_LANES
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
    end else if (in_fire) begin
      if (wr_ptr_q == IDX_W'(`NUM_LANES - 1)) begin
        wr_ptr_q <= '0;
      end else begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/rv_decode_config.svh ====
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// ==================================================
// datapath width
// ==================================================
`define XLEN 64

// ==================================================
// lane count and pointer width
// ==================================================
`define NUM_LANES 3
`define LANE_IDX_W $clog2(`NUM_LANES)

`endif

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ==================================================
  // major opcodes, inst[6:0]
  // ==================================================
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  // funct7 groups for register forms
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // branch conditions, funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_funct_e;

  // ==================================================
  // alu operations, imm and reg forms share a code
  // ==================================================
  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_ADDW,
    ALU_SUB,
    ALU_SUBW,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SLLW,
    ALU_SRL,
    ALU_SRLW,
    ALU_SRA,
    ALU_SRAW,
    ALU_MUL,
    ALU_MULW,
    ALU_DIV,
    ALU_DIVU,
    ALU_DIVW,
    ALU_DIVUW,
    ALU_REM,
    ALU_REMU,
    ALU_REMW,
    ALU_REMUW
  } alu_op_e;

  // load/store size and signedness
  typedef enum logic [2:0] {
    MEM_NONE,
    MEM_B,
    MEM_BU,
    MEM_H,
    MEM_HU,
    MEM_W,
    MEM_WU,
    MEM_D
  } mem_width_e;

endpackage
